//--- Makefile
# Verilator build and run for the arm_pipe testbench

VERILATOR ?= verilator
TOP       ?= arm_pipe_tb
FILELIST  ?= arm_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/arm_pipe_macros.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- arm_pipe.f
+incdir+logic
logic/arm_pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/arm_pipe.sv
dv/arm_pipe_asserts.sv
dv/arm_pipe_tb.sv

//--- dv/arm_pipe_asserts.sv
// --------------------
// Bound assertions on fetch, memory write and writeback
// --------------------
`default_nettype none

module arm_pipe_asserts
(
   input wire                         clock,
   input wire                         reset,
   input wire                         imem_hold,
   input wire arm_pipe_pkg::pc_t      pc,
   input wire                         pipe_mem_write,
   input wire                         wb_reg_write,
   input wire arm_pipe_pkg::reg_idx_t wb_idx
);

   // Fetch address frozen while the host owns the instruction memory
   pc_hold_a : assert property (@(posedge clock) disable iff (reset)
      imem_hold |=> $stable(pc))
      else $error("PC changed while imem_hold was high");

   // EX/MEM comes out of reset with no store pending
   no_store_after_reset_a : assert property (@(posedge clock)
      $fell(reset) |-> !pipe_mem_write)
      else $error("Pipeline data memory write right after reset");

   wb_idx_known_a : assert property (@(posedge clock) disable iff (reset)
      wb_reg_write |-> !$isunknown(wb_idx))
      else $error("Writeback index unknown while reg_write is high");

endmodule

bind arm_pipe arm_pipe_asserts arm_pipe_asserts_i
(
   .clock          (clock),
   .reset          (reset),
   .imem_hold      (host_req_i.imem_hold),
   .pc             (fetch_stage_i.pc_q),
   .pipe_mem_write (ex_mem.mem_write),
   .wb_reg_write   (wb.reg_write),
   .wb_idx         (wb.idx)
);

`default_nettype wire

//--- dv/arm_pipe_tb.sv
// --------------------
// Host tasks, program builder and directed tests
// --------------------
`default_nettype none

`include "arm_pipe_macros.svh"

module arm_pipe_tb;

   localparam int WRITE_CYCLES = 2;
   localparam int READ_CYCLES  = 4;
   localparam int RESET_CYCLES = 3;
   localparam int PROG_SLOTS   = 32;
   localparam int DRAIN_CYCLES = 48;
   localparam int LOAD_CYCLES  = PROG_SLOTS * WRITE_CYCLES + RESET_CYCLES;
   // Summed length of the five tests in clock cycles
   localparam int TEST_CYCLES  = RESET_CYCLES
      + 8 * (WRITE_CYCLES + READ_CYCLES) + RESET_CYCLES + 8 * (WRITE_CYCLES + READ_CYCLES)
      + LOAD_CYCLES + DRAIN_CYCLES + 4 * READ_CYCLES
      + 2 * WRITE_CYCLES + LOAD_CYCLES + DRAIN_CYCLES + READ_CYCLES
      + LOAD_CYCLES + DRAIN_CYCLES + 10 * READ_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic                    clock = 1'b0;
   logic                    reset;
   arm_pipe_pkg::host_req_t host_req;
   arm_pipe_pkg::instr_t    host_imem_rdata;
   arm_pipe_pkg::word_t     host_dmem_rdata;
   arm_pipe_pkg::instr_t    prog [PROG_SLOTS];
   integer                  seed;
   int                      cycle_count = 0;
   logic                    verdict_done = 1'b0;

   arm_pipe arm_pipe_i
   (
      .clock             (clock),
      .reset             (reset),
      .host_req_i        (host_req),
      .host_imem_rdata_o (host_imem_rdata),
      .host_dmem_rdata_o (host_dmem_rdata)
   );

   initial
   begin
      forever #20 clock = ~clock;
   end

   always @(posedge clock) cycle_count <= cycle_count + 1;

   initial
   begin
      wait (cycle_count >= TIMEOUT_CYCLES);
      verdict_done = 1'b1;
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("TESTS FAILED");
      $fatal(1, "Simulation timed out");
   end

   // Catches runs that stop on an assertion
   final
   begin
      if (!verdict_done)
      begin
         $display("TESTS FAILED");
      end
   end

   // Signed widening copies bit 11 into the upper bits
   function automatic arm_pipe_pkg::word_t sext12(input logic [11:0] imm);
      return arm_pipe_pkg::word_t'(signed'(imm));
   endfunction

   task automatic check_instr(input string name, input arm_pipe_pkg::instr_t exp,
                              input arm_pipe_pkg::instr_t act);
      if (act !== exp)
      begin
         verdict_done = 1'b1;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "Instruction mismatch in %s", name);
      end
   endtask

   task automatic check_word(input string name, input arm_pipe_pkg::word_t exp,
                             input arm_pipe_pkg::word_t act);
      if (act !== exp)
      begin
         verdict_done = 1'b1;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "Data word mismatch in %s", name);
      end
   endtask

   task automatic apply_reset();
      @(negedge clock);
      reset = 1'b1;
      repeat (2) @(negedge clock);
      reset = 1'b0;
   endtask

   task automatic host_imem_write(input arm_pipe_pkg::pc_t addr,
                                  input arm_pipe_pkg::instr_t data);
      @(negedge clock);
      host_req.addr    = addr;
      host_req.wdata   = {32'h0, data};
      host_req.imem_we = 1'b1;
      @(negedge clock);
      host_req.imem_we = 1'b0;
   endtask

   task automatic host_dmem_write(input arm_pipe_pkg::daddr_t addr,
                                  input arm_pipe_pkg::word_t data);
      @(negedge clock);
      host_req.addr    = {1'b0, addr};
      host_req.wdata   = data;
      host_req.dmem_we = 1'b1;
      @(negedge clock);
      host_req.dmem_we = 1'b0;
   endtask

   // Read data lands two edges after the address
   task automatic host_imem_read(input arm_pipe_pkg::pc_t addr,
                                 output arm_pipe_pkg::instr_t data);
      @(negedge clock);
      host_req.addr = addr;
      repeat (2) @(posedge clock);
      @(negedge clock);
      data = host_imem_rdata;
   endtask

   task automatic host_dmem_read(input arm_pipe_pkg::daddr_t addr,
                                 output arm_pipe_pkg::word_t data);
      @(negedge clock);
      host_req.addr = {1'b0, addr};
      repeat (2) @(posedge clock);
      @(negedge clock);
      data = host_dmem_rdata;
   endtask

   task automatic clear_program();
      for (int i = 0; i < PROG_SLOTS; i++)
      begin
         prog[i] = {4'h0, `ARM_PIPE_OPC_NOP, 20'h0};
      end
   endtask

   // Opcode in 27:20, rn 19:16, rd 15:12, imm 11:0 and rm in 3:0
   task automatic put_instr(input int slot, input arm_pipe_pkg::opcode_t opc,
                            input arm_pipe_pkg::reg_idx_t rn,
                            input arm_pipe_pkg::reg_idx_t rd, input logic [11:0] imm);
      prog[slot] = {4'h0, opc, rn, rd, imm};
   endtask

   task automatic load_program();
      host_req.imem_hold = 1'b1;
      for (int i = 0; i < PROG_SLOTS; i++)
      begin
         host_imem_write(arm_pipe_pkg::pc_t'(i), prog[i]);
      end
      apply_reset();
      host_req.imem_hold = 1'b0;
   endtask

   // Let the program run out, then freeze fetch for host reads
   task automatic drain_and_hold();
      repeat (DRAIN_CYCLES) @(negedge clock);
      host_req.imem_hold = 1'b1;
   endtask

   task automatic test_imem_access();
      arm_pipe_pkg::instr_t words [8];
      arm_pipe_pkg::instr_t got;
      for (int i = 0; i < 8; i++)
      begin
         words[i] = $random(seed);
         host_imem_write(arm_pipe_pkg::pc_t'(i * 4 + 1), words[i]);
      end
      for (int i = 0; i < 8; i++)
      begin
         host_imem_read(arm_pipe_pkg::pc_t'(i * 4 + 1), got);
         check_instr("imem_access", words[i], got);
      end
   endtask

   task automatic test_dmem_access();
      arm_pipe_pkg::word_t words [8];
      arm_pipe_pkg::word_t got;
      apply_reset();
      check_word("dmem_reset_marker", `ARM_PIPE_RDATA_RESET, host_dmem_rdata);
      check_instr("imem_reset_marker", 32'hBADABDAB, host_imem_rdata);
      for (int i = 0; i < 8; i++)
      begin
         words[i] = {$random(seed), $random(seed)};
         host_dmem_write(arm_pipe_pkg::daddr_t'(i * 37 + 5), words[i]);
      end
      for (int i = 0; i < 8; i++)
      begin
         host_dmem_read(arm_pipe_pkg::daddr_t'(i * 37 + 5), got);
         check_word("dmem_access", words[i], got);
      end
   endtask

   task automatic test_alu_ops();
      logic [11:0]         imm_a;
      logic [11:0]         imm_b;
      arm_pipe_pkg::word_t a;
      arm_pipe_pkg::word_t b;
      arm_pipe_pkg::word_t got;
      imm_a = 12'h9A5;
      imm_b = 12'h3C7;
      a = sext12(imm_a);
      b = sext12(imm_b);
      clear_program();
      put_instr(0, `ARM_PIPE_OPC_ADDI, 4'd0, 4'd1, imm_a);
      put_instr(1, `ARM_PIPE_OPC_ADDI, 4'd0, 4'd2, imm_b);
      // Three NOPs before the operands are visible
      put_instr(5, `ARM_PIPE_OPC_ADD, 4'd1, 4'd3, 12'd2);
      put_instr(6, `ARM_PIPE_OPC_SUB, 4'd1, 4'd4, 12'd2);
      put_instr(7, `ARM_PIPE_OPC_AND, 4'd1, 4'd5, 12'd2);
      put_instr(8, `ARM_PIPE_OPC_ORR, 4'd1, 4'd6, 12'd2);
      for (int i = 0; i < 4; i++)
      begin
         put_instr(12 + i, `ARM_PIPE_OPC_STR, 4'd0, arm_pipe_pkg::reg_idx_t'(3 + i),
                   12'(16 + i));
      end
      load_program();
      drain_and_hold();
      host_dmem_read(8'd16, got);
      check_word("alu_add", a + b, got);
      host_dmem_read(8'd17, got);
      check_word("alu_sub", a - b, got);
      host_dmem_read(8'd18, got);
      check_word("alu_and", a & b, got);
      host_dmem_read(8'd19, got);
      check_word("alu_orr", a | b, got);
   endtask

   task automatic test_loads();
      arm_pipe_pkg::word_t x;
      arm_pipe_pkg::word_t y;
      arm_pipe_pkg::word_t got;
      x = {$random(seed), $random(seed)};
      y = {$random(seed), $random(seed)};
      host_dmem_write(8'd40, x);
      host_dmem_write(8'd41, y);
      clear_program();
      put_instr(0, `ARM_PIPE_OPC_LDR, 4'd0, 4'd1, 12'd40);
      put_instr(1, `ARM_PIPE_OPC_LDR, 4'd0, 4'd2, 12'd41);
      put_instr(5, `ARM_PIPE_OPC_ADD, 4'd1, 4'd3, 12'd2);
      put_instr(9, `ARM_PIPE_OPC_STR, 4'd0, 4'd3, 12'd42);
      load_program();
      drain_and_hold();
      host_dmem_read(8'd42, got);
      check_word("load_add", x + y, got);
   endtask

   // Two interleaved chains where step i goes to r(i+1) and to address 64+i
   task automatic test_random_chain();
      arm_pipe_pkg::word_t model [10];
      arm_pipe_pkg::word_t got;
      logic [31:0]         raw;
      logic [11:0]         imm;
      int                  grp;
      int                  slot;
      clear_program();
      for (int i = 0; i < 10; i++)
      begin
         raw  = $random(seed);
         imm  = raw[11:0];
         grp  = i / 2;
         slot = 4 * grp + i % 2;
         if (grp == 0)
         begin
            put_instr(slot, `ARM_PIPE_OPC_ADDI, 4'd0, arm_pipe_pkg::reg_idx_t'(i + 1), imm);
            model[i] = sext12(imm);
         end
         else if (grp % 2 == 1)
         begin
            put_instr(slot, `ARM_PIPE_OPC_ADD, arm_pipe_pkg::reg_idx_t'(i - 1),
                      arm_pipe_pkg::reg_idx_t'(i + 1), 12'(i - 1));
            model[i] = model[i - 2] + model[i - 2];
         end
         else
         begin
            put_instr(slot, `ARM_PIPE_OPC_ADDI, arm_pipe_pkg::reg_idx_t'(i - 1),
                      arm_pipe_pkg::reg_idx_t'(i + 1), imm);
            model[i] = model[i - 2] + sext12(imm);
         end
         put_instr(slot + 6, `ARM_PIPE_OPC_STR, 4'd0, arm_pipe_pkg::reg_idx_t'(i + 1),
                   12'(64 + i));
      end
      load_program();
      drain_and_hold();
      for (int i = 0; i < 10; i++)
      begin
         host_dmem_read(arm_pipe_pkg::daddr_t'(64 + i), got);
         check_word("random_chain", model[i], got);
      end
   endtask

   initial
   begin
      host_req           = '0;
      host_req.imem_hold = 1'b1;
      reset              = 1'b1;
      seed               = 32'heee6_f25f;
      repeat (2) @(negedge clock);
      reset = 1'b0;
      test_imem_access();
      test_dmem_access();
      test_alu_ops();
      test_loads();
      test_random_chain();
      verdict_done = 1'b1;
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/arm_pipe.sv
// --------------------
// Five-stage pipeline top with host port
// --------------------
`default_nettype none

module arm_pipe
(
   input  wire                     clock,
   input  wire                     reset,
   input  wire arm_pipe_pkg::host_req_t host_req_i,
   output arm_pipe_pkg::instr_t    host_imem_rdata_o,
   output arm_pipe_pkg::word_t     host_dmem_rdata_o
);

   arm_pipe_pkg::if_id_t  if_id;
   arm_pipe_pkg::id_ex_t  id_ex;
   arm_pipe_pkg::ex_mem_t ex_mem;
   arm_pipe_pkg::wb_t     wb;

   fetch_stage fetch_stage_i
   (
      .clock             (clock),
      .reset             (reset),
      .host_req_i        (host_req_i),
      .if_id_o           (if_id),
      .host_imem_rdata_o (host_imem_rdata_o)
   );

   decode_stage decode_stage_i
   (
      .clock    (clock),
      .reset    (reset),
      .if_id_i  (if_id),
      .wb_i     (wb),
      .id_ex_o  (id_ex)
   );

   execute_stage execute_stage_i
   (
      .clock     (clock),
      .reset     (reset),
      .id_ex_i   (id_ex),
      .ex_mem_o  (ex_mem)
   );

   // Writeback loops back from memory stage to the register file
   memory_stage memory_stage_i
   (
      .clock             (clock),
      .reset             (reset),
      .ex_mem_i          (ex_mem),
      .host_req_i        (host_req_i),
      .wb_o              (wb),
      .host_dmem_rdata_o (host_dmem_rdata_o)
   );

endmodule

`default_nettype wire

//--- logic/arm_pipe_macros.svh
// --------------------
// Widths, depths, opcode codes and ALU control codes
// --------------------
`ifndef ARM_PIPE_MACROS_SVH
`define ARM_PIPE_MACROS_SVH

// Datapath widths
`define ARM_PIPE_DATA_W        64
`define ARM_PIPE_INSTR_W       32
`define ARM_PIPE_OPC_W         8
`define ARM_PIPE_REG_ADDR_W    4

// Memory sizes
`define ARM_PIPE_IMEM_DEPTH    512
`define ARM_PIPE_PC_W          9
`define ARM_PIPE_DMEM_DEPTH    256
`define ARM_PIPE_DMEM_ADDR_W   8

// Opcodes in instruction bits 27:20
`define ARM_PIPE_OPC_NOP       8'h00
`define ARM_PIPE_OPC_ADD       8'h01
`define ARM_PIPE_OPC_SUB       8'h02
`define ARM_PIPE_OPC_AND       8'h03
`define ARM_PIPE_OPC_ORR       8'h04
`define ARM_PIPE_OPC_ADDI      8'h05
`define ARM_PIPE_OPC_LDR       8'h06
`define ARM_PIPE_OPC_STR       8'h07

// Control unit classes for ALU control
`define ARM_PIPE_ALUOP_ADD     2'b00
`define ARM_PIPE_ALUOP_RTYPE   2'b10

// ALU operations
`define ARM_PIPE_ALU_AND       4'b0000
`define ARM_PIPE_ALU_ORR       4'b0001
`define ARM_PIPE_ALU_ADD       4'b0010
`define ARM_PIPE_ALU_SUB       4'b0110

// Host read data until the first real read
`define ARM_PIPE_RDATA_RESET   64'hBADABDAB_BADABDAB

`endif

//--- logic/arm_pipe_pkg.sv
// --------------------
// Vector types and pipeline register structs
// --------------------
`default_nettype none

`include "arm_pipe_macros.svh"

package arm_pipe_pkg;

   typedef logic [`ARM_PIPE_DATA_W-1:0]      word_t;
   typedef logic [`ARM_PIPE_INSTR_W-1:0]     instr_t;
   typedef logic [`ARM_PIPE_PC_W-1:0]        pc_t;
   typedef logic [`ARM_PIPE_DMEM_ADDR_W-1:0] daddr_t;
   typedef logic [`ARM_PIPE_REG_ADDR_W-1:0]  reg_idx_t;
   typedef logic [`ARM_PIPE_OPC_W-1:0]       opcode_t;
   typedef logic [1:0]                       alu_op_t;
   typedef logic [3:0]                       alu_ctl_t;

   // Decoded controls, all low for a NOP
   typedef struct packed {
      logic    alu_src;
      logic    mem_write;
      logic    mem_read;
      logic    mem_to_reg;
      logic    reg_write;
      alu_op_t alu_op;
   } ctrl_t;

   typedef struct packed {
      instr_t instr;
   } if_id_t;

   typedef struct packed {
      ctrl_t    ctrl;
      opcode_t  opcode;
      word_t    rn_data;
      // rm for register ops, rd for stores
      word_t    rm_data;
      word_t    imm;
      reg_idx_t rd;
   } id_ex_t;

   typedef struct packed {
      logic     mem_write;
      logic     mem_read;
      logic     mem_to_reg;
      logic     reg_write;
      word_t    alu_result;
      word_t    store_data;
      reg_idx_t rd;
   } ex_mem_t;

   typedef struct packed {
      logic     mem_to_reg;
      logic     reg_write;
      word_t    load_data;
      word_t    alu_result;
      reg_idx_t rd;
   } mem_wb_t;

   typedef struct packed {
      logic     reg_write;
      reg_idx_t idx;
      word_t    data;
   } wb_t;

   // Host port, plain levels and strobes
   typedef struct packed {
      logic  imem_hold;
      logic  imem_we;
      logic  dmem_we;
      pc_t   addr;
      word_t wdata;
   } host_req_t;

endpackage

`default_nettype wire

//--- logic/decode_stage.sv
// --------------------
// Control unit, register file, sign extension, ID/EX register
// --------------------
`default_nettype none

`include "arm_pipe_macros.svh"

module decode_stage
(
   input  wire                    clock,
   input  wire                    reset,
   input  wire arm_pipe_pkg::if_id_t if_id_i,
   input  wire arm_pipe_pkg::wb_t    wb_i,
   output arm_pipe_pkg::id_ex_t   id_ex_o
);

   localparam int NUM_REGS = 1 << `ARM_PIPE_REG_ADDR_W;

   arm_pipe_pkg::opcode_t  opcode;
   arm_pipe_pkg::reg_idx_t rn_idx;
   arm_pipe_pkg::reg_idx_t rd_idx;
   arm_pipe_pkg::reg_idx_t rm_idx;
   arm_pipe_pkg::reg_idx_t r2_idx;
   arm_pipe_pkg::ctrl_t    ctrl;
   logic                   reg2loc;
   arm_pipe_pkg::word_t    rn_data;
   arm_pipe_pkg::word_t    r2_data;
   arm_pipe_pkg::word_t    imm_ext;
   arm_pipe_pkg::word_t    regs [NUM_REGS];

   // Instruction fields, rm overlaps the low immediate bits
   assign opcode = if_id_i.instr[27:20];
   assign rn_idx = if_id_i.instr[19:16];
   assign rd_idx = if_id_i.instr[15:12];
   assign rm_idx = if_id_i.instr[3:0];

   // Control unit
   always_comb
   begin
      ctrl        = '0;
      ctrl.alu_op = `ARM_PIPE_ALUOP_ADD;
      reg2loc     = 1'b0;
      case (opcode)
         `ARM_PIPE_OPC_ADD,
         `ARM_PIPE_OPC_SUB,
         `ARM_PIPE_OPC_AND,
         `ARM_PIPE_OPC_ORR:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = `ARM_PIPE_ALUOP_RTYPE;
         end
         `ARM_PIPE_OPC_ADDI:
         begin
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         `ARM_PIPE_OPC_LDR:
         begin
            ctrl.alu_src    = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.reg_write  = 1'b1;
         end
         `ARM_PIPE_OPC_STR:
         begin
            ctrl.alu_src   = 1'b1;
            ctrl.mem_write = 1'b1;
            // Store data comes from rd
            reg2loc        = 1'b1;
         end
         default:
         begin
            // NOP and unknown opcodes
            ctrl = '0;
         end
      endcase
   end

   assign r2_idx = reg2loc ? rd_idx : rm_idx;

   // Register file, written from writeback, no bypass to the read ports
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wb_i.reg_write)
      begin
         regs[wb_i.idx] <= wb_i.data;
      end
   end

   assign rn_data = regs[rn_idx];
   assign r2_data = regs[r2_idx];

   assign imm_ext = {{(`ARM_PIPE_DATA_W-12){if_id_i.instr[11]}}, if_id_i.instr[11:0]};

   // ID/EX
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         id_ex_o.ctrl <= '0;
      end
      else
      begin
         id_ex_o.ctrl    <= ctrl;
         id_ex_o.opcode  <= opcode;
         id_ex_o.rn_data <= rn_data;
         id_ex_o.rm_data <= r2_data;
         id_ex_o.imm     <= imm_ext;
         id_ex_o.rd      <= rd_idx;
      end
   end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
// --------------------
// ALU source select, ALU control, ALU, EX/MEM register
// --------------------
`default_nettype none

`include "arm_pipe_macros.svh"

module execute_stage
(
   input  wire                     clock,
   input  wire                     reset,
   input  wire arm_pipe_pkg::id_ex_t  id_ex_i,
   output arm_pipe_pkg::ex_mem_t   ex_mem_o
);

   arm_pipe_pkg::word_t    alu_b;
   arm_pipe_pkg::alu_ctl_t alu_ctl;
   arm_pipe_pkg::word_t    alu_result;

   // Immediate for ADDI and address calculation
   assign alu_b = id_ex_i.ctrl.alu_src ? id_ex_i.imm : id_ex_i.rm_data;

   // ALU control
   always_comb
   begin
      alu_ctl = `ARM_PIPE_ALU_ADD;
      if (id_ex_i.ctrl.alu_op == `ARM_PIPE_ALUOP_RTYPE)
      begin
         case (id_ex_i.opcode)
            `ARM_PIPE_OPC_SUB:
            begin
               alu_ctl = `ARM_PIPE_ALU_SUB;
            end
            `ARM_PIPE_OPC_AND:
            begin
               alu_ctl = `ARM_PIPE_ALU_AND;
            end
            `ARM_PIPE_OPC_ORR:
            begin
               alu_ctl = `ARM_PIPE_ALU_ORR;
            end
            default:
            begin
               alu_ctl = `ARM_PIPE_ALU_ADD;
            end
         endcase
      end
   end

   // ALU, two's complement wraps at 64 bits
   always_comb
   begin
      case (alu_ctl)
         `ARM_PIPE_ALU_SUB: alu_result = id_ex_i.rn_data - alu_b;
         `ARM_PIPE_ALU_AND: alu_result = id_ex_i.rn_data & alu_b;
         `ARM_PIPE_ALU_ORR: alu_result = id_ex_i.rn_data | alu_b;
         default:           alu_result = id_ex_i.rn_data + alu_b;
      endcase
   end

   // EX/MEM
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         ex_mem_o.mem_write  <= 1'b0;
         ex_mem_o.mem_read   <= 1'b0;
         ex_mem_o.mem_to_reg <= 1'b0;
         ex_mem_o.reg_write  <= 1'b0;
      end
      else
      begin
         ex_mem_o.mem_write  <= id_ex_i.ctrl.mem_write;
         ex_mem_o.mem_read   <= id_ex_i.ctrl.mem_read;
         ex_mem_o.mem_to_reg <= id_ex_i.ctrl.mem_to_reg;
         ex_mem_o.reg_write  <= id_ex_i.ctrl.reg_write;
         ex_mem_o.alu_result <= alu_result;
         ex_mem_o.store_data <= id_ex_i.rm_data;
         ex_mem_o.rd         <= id_ex_i.rd;
      end
   end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
// --------------------
// PC, instruction memory with host access, IF/ID register
// --------------------
`default_nettype none

`include "arm_pipe_macros.svh"

module fetch_stage
(
   input  wire                     clock,
   input  wire                     reset,
   input  wire arm_pipe_pkg::host_req_t host_req_i,
   output arm_pipe_pkg::if_id_t    if_id_o,
   output arm_pipe_pkg::instr_t    host_imem_rdata_o
);

   localparam arm_pipe_pkg::instr_t NOP_INSTR = {4'h0, `ARM_PIPE_OPC_NOP, 20'h0};

   arm_pipe_pkg::pc_t    pc_q;
   arm_pipe_pkg::pc_t    imem_addr;
   arm_pipe_pkg::instr_t imem_dout_q;
   logic                 fetch_valid_q;
   arm_pipe_pkg::instr_t imem [`ARM_PIPE_IMEM_DEPTH];

   // Empty memory decodes as all NOPs
   initial
   begin
      for (int i = 0; i < `ARM_PIPE_IMEM_DEPTH; i++)
      begin
         imem[i] = NOP_INSTR;
      end
   end

   // PC steps by one word and wraps, frozen while host owns the memory
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         pc_q <= '0;
      end
      else if (!host_req_i.imem_hold)
      begin
         pc_q <= pc_q + arm_pipe_pkg::pc_t'(1);
      end
   end

   assign imem_addr = host_req_i.imem_hold ? host_req_i.addr : pc_q;

   // Single port shared between fetch and host
   always_ff @(posedge clock)
   begin
      if (host_req_i.imem_hold && host_req_i.imem_we)
      begin
         imem[host_req_i.addr] <= host_req_i.wdata[`ARM_PIPE_INSTR_W-1:0];
      end
      imem_dout_q <= imem[imem_addr];
   end

   // Marks whether imem_dout_q came from the PC or from a host address
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         fetch_valid_q <= 1'b0;
      end
      else
      begin
         fetch_valid_q <= !host_req_i.imem_hold;
      end
   end

   // IF/ID, NOP whenever the read was a host access
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         if_id_o.instr <= NOP_INSTR;
      end
      else if (fetch_valid_q)
      begin
         if_id_o.instr <= imem_dout_q;
      end
      else
      begin
         if_id_o.instr <= NOP_INSTR;
      end
   end

   // Host read data only tracks the memory while held
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         host_imem_rdata_o <= arm_pipe_pkg::instr_t'(`ARM_PIPE_RDATA_RESET);
      end
      else if (host_req_i.imem_hold)
      begin
         host_imem_rdata_o <= imem_dout_q;
      end
   end

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
// --------------------
// Dual-port data memory, MEM/WB register, writeback select
// --------------------
`default_nettype none

`include "arm_pipe_macros.svh"

module memory_stage
(
   input  wire                     clock,
   input  wire                     reset,
   input  wire arm_pipe_pkg::ex_mem_t   ex_mem_i,
   input  wire arm_pipe_pkg::host_req_t host_req_i,
   output arm_pipe_pkg::wb_t       wb_o,
   output arm_pipe_pkg::word_t     host_dmem_rdata_o
);

   arm_pipe_pkg::daddr_t  pipe_addr;
   arm_pipe_pkg::daddr_t  host_addr;
   arm_pipe_pkg::word_t   host_dout_q;
   arm_pipe_pkg::mem_wb_t mem_wb_q;
   arm_pipe_pkg::word_t   dmem [`ARM_PIPE_DMEM_DEPTH];

   assign pipe_addr = ex_mem_i.alu_result[`ARM_PIPE_DMEM_ADDR_W-1:0];
   assign host_addr = host_req_i.addr[`ARM_PIPE_DMEM_ADDR_W-1:0];

   // Port one is the pipeline, port two the host
   always_ff @(posedge clock)
   begin
      if (ex_mem_i.mem_write)
      begin
         dmem[pipe_addr] <= ex_mem_i.store_data;
      end
      if (host_req_i.dmem_we)
      begin
         dmem[host_addr] <= host_req_i.wdata;
      end
      host_dout_q <= dmem[host_addr];
   end

   // Second register stage on the host read path
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         host_dmem_rdata_o <= `ARM_PIPE_RDATA_RESET;
      end
      else
      begin
         host_dmem_rdata_o <= host_dout_q;
      end
   end

   // MEM/WB, load data is the synchronous port one read
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         mem_wb_q.mem_to_reg <= 1'b0;
         mem_wb_q.reg_write  <= 1'b0;
      end
      else
      begin
         mem_wb_q.mem_to_reg <= ex_mem_i.mem_to_reg;
         mem_wb_q.reg_write  <= ex_mem_i.reg_write;
         mem_wb_q.alu_result <= ex_mem_i.alu_result;
         mem_wb_q.rd         <= ex_mem_i.rd;
         if (ex_mem_i.mem_read)
         begin
            mem_wb_q.load_data <= dmem[pipe_addr];
         end
      end
   end

   // Writeback select
   always_comb
   begin
      wb_o.reg_write = mem_wb_q.reg_write;
      wb_o.idx       = mem_wb_q.rd;
      wb_o.data      = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
   end

endmodule

`default_nettype wire
